// File: src.f
or_ctrl_pkg.sv
id_stage.sv
ex_decode.sv
forward_select.sv
or_ctrl.sv
tb_clock_gen.sv
tb_or_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it
# exit status is nonzero when the run fails
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f src.f --top-module tb_or_ctrl -o tb_or_ctrl
./obj_dir/tb_or_ctrl

// File: tb_or_ctrl.sv
////////////////////////////////////////
// table-driven run that checks every output once per cycle
// expects link_reg left at its default of 9
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_or_ctrl;

	import or_ctrl_pkg::*;

	localparam int n_rows = 80;
	localparam logic [31:0] nop_word = 32'h1401_0000;

	// control column bits
	localparam logic [6:0] c_none = 7'h00;
	localparam logic [6:0] c_idf  = 7'h01;
	localparam logic [6:0] c_exf  = 7'h02;
	localparam logic [6:0] c_wbf  = 7'h04;
	localparam logic [6:0] c_exfl = 7'h08;
	localparam logic [6:0] c_pcwe = 7'h10;
	localparam logic [6:0] c_hwbk = 7'h20;
	localparam logic [6:0] c_wbv  = 7'h40;

	logic        clk;
	logic        rst_n;
	logic [31:0] if_insn;
	logic [31:0] id_pc;
	logic        id_freeze;
	logic        ex_freeze;
	logic        wb_freeze;
	logic        except_flushpipe;
	logic        pc_we;
	logic        du_hwbkpt;
	logic        wbforw_valid;

	wire         flushpipe;
	wire  [31:0] id_insn;
	wire  [31:0] ex_insn;
	wire  [31:0] wb_insn;
	wire  [4:0]  rf_addra;
	wire  [4:0]  rf_addrb;
	wire  [31:0] id_simm;
	wire  [29:0] id_branch_target;
	wire  [2:0]  id_branch_op;
	wire  [2:0]  ex_branch_op;
	wire  [4:0]  alu_op;
	wire  [3:0]  rfwb_op;
	wire  [4:0]  rf_addrw;
	wire  [1:0]  sel_a;
	wire  [1:0]  sel_b;
	wire         except_illegal;
	wire         sig_syscall;
	wire         sig_trap;

	// reference model state
	logic [31:0] m_id_insn;
	logic [2:0]  m_id_br;
	logic        m_sel_imm;
	logic [31:0] m_ex_insn;
	logic [2:0]  m_ex_br;
	logic [4:0]  m_alu;
	logic [3:0]  m_rfwb;
	logic [4:0]  m_addrw;
	logic        m_ill;
	logic        m_sys;
	logic        m_trap;
	logic [31:0] m_wb_insn;
	logic [4:0]  m_wb_addrw;

	// stimulus table
	logic [31:0] tab_insn [n_rows];
	logic [31:0] tab_pc   [n_rows];
	logic [6:0]  tab_ctl  [n_rows];
	int          n_fill;
	integer      seed;

	// the kept opcodes followed by three illegal ones
	logic [5:0] op_pool [22] = '{
		6'h00, 6'h01, 6'h03, 6'h04, 6'h05, 6'h06, 6'h08, 6'h09, 6'h11, 6'h12, 6'h21,
		6'h27, 6'h29, 6'h2a, 6'h2b, 6'h2f, 6'h35, 6'h38, 6'h39, 6'h02, 6'h1c, 6'h3e
	};

	tb_clock_gen i_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	or_ctrl i_dut (
		.clk              (clk),
		.rst_n            (rst_n),
		.if_insn          (if_insn),
		.id_pc            (id_pc),
		.id_freeze        (id_freeze),
		.ex_freeze        (ex_freeze),
		.wb_freeze        (wb_freeze),
		.except_flushpipe (except_flushpipe),
		.pc_we            (pc_we),
		.du_hwbkpt        (du_hwbkpt),
		.wbforw_valid     (wbforw_valid),
		.flushpipe        (flushpipe),
		.id_insn          (id_insn),
		.ex_insn          (ex_insn),
		.wb_insn          (wb_insn),
		.rf_addra         (rf_addra),
		.rf_addrb         (rf_addrb),
		.id_simm          (id_simm),
		.id_branch_target (id_branch_target),
		.id_branch_op     (id_branch_op),
		.ex_branch_op     (ex_branch_op),
		.alu_op           (alu_op),
		.rfwb_op          (rfwb_op),
		.rf_addrw         (rf_addrw),
		.sel_a            (sel_a),
		.sel_b            (sel_b),
		.except_illegal   (except_illegal),
		.sig_syscall      (sig_syscall),
		.sig_trap         (sig_trap)
	);

	task automatic abort_run(input string msg);
		$display("Test FAILED");
		$fatal(1, "%s", msg);
	endtask

	task automatic expect_equal(input string name, input logic [31:0] act,
		input logic [31:0] exp);
		if (act !== exp) begin
			$display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, act, exp);
			abort_run("output mismatch");
		end
	endtask

	////////////////////////////////////////
	// instruction builders
	////////////////////////////////////////
	function automatic logic [31:0] itype(input logic [5:0] opc, input logic [4:0] rd,
		input logic [4:0] ra, input logic [15:0] imm);
		return {opc, rd, ra, imm};
	endfunction

	function automatic logic [31:0] rtype(input logic [5:0] opc, input logic [4:0] rd,
		input logic [4:0] ra, input logic [4:0] rb, input logic [3:0] fn);
		return {opc, rd, ra, rb, 7'd0, fn};
	endfunction

	// store offset goes around rB
	function automatic logic [31:0] stype(input logic [15:0] imm, input logic [4:0] ra,
		input logic [4:0] rb);
		return {6'h35, imm[15:11], ra, rb, imm[10:0]};
	endfunction

	////////////////////////////////////////
	// expected decode
	////////////////////////////////////////
	function automatic logic [2:0] decode_branch(input logic [5:0] opc);
		case (opc)
			6'h00, 6'h01: return br_j;
			6'h11, 6'h12: return br_jr;
			6'h03:        return br_bnf;
			6'h04:        return br_bf;
			6'h09:        return br_rfe;
			default:      return br_nop;
		endcase
	endfunction

	function automatic logic needs_imm(input logic [5:0] opc);
		case (opc)
			6'h12, 6'h11, 6'h09, 6'h08, 6'h35, 6'h38, 6'h39, 6'h05: return 1'b0;
			default: return 1'b1;
		endcase
	endfunction

	function automatic logic [31:0] extend_imm(input logic [31:0] insn);
		case (insn[31:26])
			6'h27, 6'h21, 6'h2b, 6'h2f: return {{16{insn[15]}}, insn[15:0]};
			6'h35:   return {{16{insn[25]}}, insn[25:21], insn[10:0]};
			default: return {16'h0000, insn[15:0]};
		endcase
	endfunction

	function automatic logic [29:0] calc_target(input logic [31:0] insn,
		input logic [31:0] pc);
		logic [29:0] off;
		off = {{4{insn[25]}}, insn[25:0]};
		return off + pc[31:2];
	endfunction

	function automatic logic [4:0] decode_alu(input logic [31:0] insn);
		case (insn[31:26])
			6'h06:        return 5'h0c;
			6'h27:        return 5'h00;
			6'h29:        return 5'h03;
			6'h2a:        return 5'h04;
			6'h2b:        return 5'h05;
			6'h39, 6'h2f: return 5'h0e;
			6'h38:        return {1'b0, insn[3:0]};
			default:      return 5'h0f;
		endcase
	endfunction

	function automatic logic [3:0] decode_rfwb(input logic [5:0] opc);
		case (opc)
			6'h01, 6'h12: return rfwb_lr_w;
			6'h21:        return rfwb_lsu_w;
			6'h06, 6'h27, 6'h29, 6'h2a, 6'h2b, 6'h38: return rfwb_alu_w;
			default:      return rfwb_nop;
		endcase
	endfunction

	function automatic logic is_illegal(input logic [5:0] opc);
		case (opc)
			6'h00, 6'h01, 6'h03, 6'h04, 6'h05, 6'h06, 6'h08, 6'h09, 6'h11, 6'h12,
			6'h21, 6'h27, 6'h29, 6'h2a, 6'h2b, 6'h2f, 6'h35, 6'h38, 6'h39:
				return 1'b0;
			default:
				return 1'b1;
		endcase
	endfunction

	// EX result beats WB result beats register file
	function automatic logic [1:0] pick_source(input logic [4:0] addr);
		if (addr == m_addrw && m_rfwb[0])
			return sel_src_ex_forw;
		else if (addr == m_wb_addrw && wbforw_valid)
			return sel_src_wb_forw;
		return sel_src_rf;
	endfunction

	////////////////////////////////////////
	// model registers
	////////////////////////////////////////
	task automatic clear_ex();
		m_ex_insn = nop_word;
		m_ex_br   = br_nop;
		m_alu     = 5'h0f;
		m_rfwb    = rfwb_nop;
		m_addrw   = 5'd0;
		m_ill     = 1'b0;
		m_sys     = 1'b0;
		m_trap    = 1'b0;
	endtask

	task automatic model_reset();
		m_id_insn  = nop_word;
		m_id_br    = br_nop;
		m_sel_imm  = 1'b0;
		m_wb_insn  = nop_word;
		m_wb_addrw = 5'd0;
		clear_ex();
	endtask

	// one rising edge with the oldest stage first
	task automatic model_step();
		logic       flush;
		logic [5:0] opc;
		flush = except_flushpipe | pc_we;
		opc = m_id_insn[31:26];
		if (!wb_freeze) begin
			m_wb_insn  = m_ex_insn;
			m_wb_addrw = m_addrw;
		end
		if (!ex_freeze && (id_freeze || flush)) begin
			clear_ex();
		end else if (!ex_freeze) begin
			m_ex_insn = m_id_insn;
			m_ex_br   = m_id_br;
			m_alu     = decode_alu(m_id_insn);
			m_rfwb    = decode_rfwb(opc);
			m_addrw   = (opc == 6'h01 || opc == 6'h12) ? 5'd9 : m_id_insn[25:21];
			m_ill     = is_illegal(opc);
			m_sys     = (m_id_insn[31:23] == 9'b001000_000);
			m_trap    = (m_id_insn[31:23] == 9'b001000_010) || du_hwbkpt;
		end
		// sel_imm keeps following fetch through a flush
		if (!id_freeze)
			m_sel_imm = needs_imm(if_insn[31:26]);
		if (flush) begin
			m_id_insn = nop_word;
			m_id_br   = br_nop;
		end else if (!id_freeze) begin
			m_id_insn = if_insn;
			m_id_br   = decode_branch(if_insn[31:26]);
		end
	endtask

	task automatic check_outputs();
		expect_equal("flushpipe", 32'(flushpipe), 32'(except_flushpipe | pc_we));
		expect_equal("id_insn", id_insn, m_id_insn);
		expect_equal("ex_insn", ex_insn, m_ex_insn);
		expect_equal("wb_insn", wb_insn, m_wb_insn);
		expect_equal("rf_addra", 32'(rf_addra), 32'(if_insn[20:16]));
		expect_equal("rf_addrb", 32'(rf_addrb), 32'(if_insn[15:11]));
		expect_equal("id_simm", id_simm, extend_imm(m_id_insn));
		expect_equal("id_branch_target", 32'(id_branch_target),
			32'(calc_target(m_id_insn, id_pc)));
		expect_equal("id_branch_op", 32'(id_branch_op), 32'(m_id_br));
		expect_equal("ex_branch_op", 32'(ex_branch_op), 32'(m_ex_br));
		expect_equal("alu_op", 32'(alu_op), 32'(m_alu));
		expect_equal("rfwb_op", 32'(rfwb_op), 32'(m_rfwb));
		expect_equal("rf_addrw", 32'(rf_addrw), 32'(m_addrw));
		expect_equal("except_illegal", 32'(except_illegal), 32'(m_ill));
		expect_equal("sig_syscall", 32'(sig_syscall), 32'(m_sys));
		expect_equal("sig_trap", 32'(sig_trap), 32'(m_trap));
		expect_equal("sel_a", 32'(sel_a), 32'(pick_source(m_id_insn[20:16])));
		expect_equal("sel_b", 32'(sel_b),
			32'(m_sel_imm ? 2'(sel_src_imm) : pick_source(m_id_insn[15:11])));
	endtask

	////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////
	task automatic add_row(input logic [31:0] insn, input logic [31:0] pc,
		input logic [6:0] ctl);
		tab_insn[n_fill] = insn;
		tab_pc[n_fill]   = pc;
		tab_ctl[n_fill]  = ctl;
		n_fill++;
	endtask

	task automatic build_table();
		logic [31:0] r;
		logic [31:0] body;
		logic [31:0] insn;
		logic [6:0]  ctl;
		int          idx;
		n_fill = 0;
		// forwarding chain and immediate forms
		add_row(itype(6'h27, 5'd3, 5'd1, 16'h8005), 32'h0000_1000, c_wbv);
		add_row(itype(6'h29, 5'd4, 5'd3, 16'h8001), 32'h0000_1004, c_wbv);
		add_row(itype(6'h2a, 5'd5, 5'd4, 16'hf0f0), 32'h0000_1008, c_wbv);
		add_row(rtype(6'h38, 5'd6, 5'd4, 5'd5, 4'h4), 32'h0000_100c, c_wbv);
		add_row(rtype(6'h38, 5'd7, 5'd6, 5'd4, 4'h1), 32'h0000_1010, c_wbv);
		add_row(itype(6'h2b, 5'd8, 5'd7, 16'h8000), 32'h0000_1014, c_none);
		add_row(itype(6'h21, 5'd9, 5'd6, 16'hfffc), 32'h0000_1018, c_wbv);
		add_row(stype(16'h8123, 5'd9, 5'd8), 32'h0000_101c, c_wbv);
		add_row(itype(6'h2f, 5'd0, 5'd9, 16'h9000), 32'h0000_1020, c_none);
		add_row(rtype(6'h39, 5'd1, 5'd2, 5'd3, 4'h0), 32'h0000_1024, c_wbv);
		add_row(itype(6'h06, 5'd10, 5'd0, 16'hbeef), 32'h0000_1028, c_none);
		// forward and backward branches
		add_row({6'h01, 26'h3ff_fff0}, 32'h0000_2000, c_none);
		add_row({6'h00, 26'h000_0040}, 32'h8000_0000, c_none);
		add_row({6'h03, 26'h200_0000}, 32'h0000_0010, c_none);
		add_row({6'h04, 26'h000_0003}, 32'hffff_fff0, c_none);
		add_row(rtype(6'h12, 5'd0, 5'd0, 5'd9, 4'h0), 32'h0000_3000, c_wbv);
		add_row(rtype(6'h11, 5'd0, 5'd0, 5'd9, 4'h0), 32'h0000_3004, c_wbv);
		add_row({6'h09, 26'h000_0000}, 32'h0000_3008, c_none);
		// l.sys, l.trap, another sync, breakpoint, illegal
		add_row({6'h08, 3'b000, 23'h00_0005}, 32'h0000_4000, c_none);
		add_row({6'h08, 3'b010, 23'h00_0001}, 32'h0000_4004, c_none);
		add_row({6'h08, 3'b101, 23'h00_0000}, 32'h0000_4008, c_none);
		add_row(itype(6'h2a, 5'd2, 5'd2, 16'h0001), 32'h0000_400c, c_none);
		add_row({6'h02, 26'h155_5555}, 32'h0000_4010, c_hwbk);
		add_row({6'h3f, 26'h000_0000}, 32'h0000_4014, c_none);
		add_row(nop_word, 32'h0000_4018, c_none);
		// freeze, bubble and flush
		add_row(itype(6'h27, 5'd11, 5'd10, 16'h0010), 32'h0000_5000, c_none);
		add_row(itype(6'h27, 5'd12, 5'd11, 16'h0020), 32'h0000_5004, c_idf);
		add_row(itype(6'h27, 5'd12, 5'd11, 16'h0020), 32'h0000_5004, c_idf);
		add_row(itype(6'h29, 5'd13, 5'd12, 16'h00ff), 32'h0000_5008, c_none);
		add_row(itype(6'h2a, 5'd14, 5'd13, 16'h0f00), 32'h0000_500c, c_exf);
		add_row(itype(6'h2a, 5'd14, 5'd13, 16'h0f00), 32'h0000_500c, c_exf | c_idf);
		add_row(itype(6'h2b, 5'd15, 5'd14, 16'h1234), 32'h0000_5010, c_wbf | c_wbv);
		add_row(itype(6'h2b, 5'd16, 5'd15, 16'h4321), 32'h0000_5014, c_exfl);
		add_row(itype(6'h06, 5'd17, 5'd16, 16'h5555), 32'h0000_5018, c_none);
		add_row({6'h01, 26'h000_0100}, 32'h0000_501c, c_pcwe);
		add_row(itype(6'h27, 5'd18, 5'd17, 16'h0001), 32'h0000_5020, c_exf | c_pcwe);
		add_row(itype(6'h27, 5'd19, 5'd18, 16'h0002), 32'h0000_5024, c_none);
		// random tail with small register numbers so forwarding hits
		while (n_fill < n_rows - 3) begin
			r = $random(seed);
			body = $random(seed);
			idx = int'(r[15:0] % 16'd22);
			insn = {op_pool[idx], body[25:0]};
			insn[25:24] = 2'b00;
			insn[20:18] = 3'b000;
			insn[15:13] = 3'b000;
			ctl = c_none;
			ctl[0] = (r[19:17] == 3'd0);
			ctl[1] = (r[22:20] == 3'd0);
			ctl[2] = (r[25:23] == 3'd0);
			ctl[3] = (r[29:26] == 4'd0);
			ctl[4] = (r[31:30] == 2'd0) && r[16];
			ctl[5] = (body[31:29] == 3'd0);
			ctl[6] = body[28];
			add_row(insn, $random(seed), ctl);
		end
		// idle rows let the last words drain
		while (n_fill < n_rows)
			add_row(nop_word, 32'h0000_0000, c_none);
	endtask

	task automatic apply_row(input int i);
		if_insn          = tab_insn[i];
		id_pc            = tab_pc[i];
		id_freeze        = tab_ctl[i][0];
		ex_freeze        = tab_ctl[i][1];
		wb_freeze        = tab_ctl[i][2];
		except_flushpipe = tab_ctl[i][3];
		pc_we            = tab_ctl[i][4];
		du_hwbkpt        = tab_ctl[i][5];
		wbforw_valid     = tab_ctl[i][6];
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////
	initial begin
		int i;
		seed             = 65;
		if_insn          = nop_word;
		id_pc            = 32'h0000_0000;
		id_freeze        = 1'b0;
		ex_freeze        = 1'b0;
		wb_freeze        = 1'b0;
		except_flushpipe = 1'b0;
		pc_we            = 1'b0;
		du_hwbkpt        = 1'b0;
		wbforw_valid     = 1'b0;
		build_table();
		model_reset();
		wait (rst_n === 1'b1);
		#1;
		check_outputs();
		for (i = 0; i < n_rows; i++) begin
			@(posedge clk);
			model_step();
			#2;
			apply_row(i);
			#3;
			check_outputs();
		end
		$display("Test OK");
		$finish;
	end

	// reset plus one cycle per row and some margin
	initial begin
		#((n_rows + 20) * 10);
		abort_run("timeout: simulation did not finish");
	end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
////////////////////////////////////////
// 10 ns clock, rst_n low for the first 8 rising edges
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// release just after the 8th rising edge
	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: or_ctrl.sv
////////////////////////////////////////
// decode and pipeline control, freeze and flush active high
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module or_ctrl #(
	parameter logic [or_ctrl_pkg::rf_addr_w-1:0] link_reg = 5'd9
) (
	input  wire                                   clk,
	input  wire                                   rst_n,
	input  wire  [31:0]                           if_insn,
	input  wire  [31:0]                           id_pc,
	input  wire                                   id_freeze,
	input  wire                                   ex_freeze,
	input  wire                                   wb_freeze,
	input  wire                                   except_flushpipe,
	input  wire                                   pc_we,
	input  wire                                   du_hwbkpt,
	input  wire                                   wbforw_valid,
	output wire                                   flushpipe,
	output wire  [31:0]                           id_insn,
	output wire  [31:0]                           ex_insn,
	output wire  [31:0]                           wb_insn,
	output wire  [or_ctrl_pkg::rf_addr_w-1:0]     rf_addra,
	output wire  [or_ctrl_pkg::rf_addr_w-1:0]     rf_addrb,
	output wire  [31:0]                           id_simm,
	output wire  [29:0]                           id_branch_target,
	output wire  or_ctrl_pkg::branch_op_t         id_branch_op,
	output wire  or_ctrl_pkg::branch_op_t         ex_branch_op,
	output wire  or_ctrl_pkg::alu_op_t            alu_op,
	output wire  or_ctrl_pkg::rfwb_op_t           rfwb_op,
	output wire  [or_ctrl_pkg::rf_addr_w-1:0]     rf_addrw,
	output wire  or_ctrl_pkg::sel_t               sel_a,
	output wire  or_ctrl_pkg::sel_t               sel_b,
	output wire                                   except_illegal,
	output wire                                   sig_syscall,
	output wire                                   sig_trap
);

	wire sel_imm;

	// exception entry or a taken PC write
	assign flushpipe = except_flushpipe | pc_we;

	id_stage u_id (
		.clk              (clk),
		.rst_n            (rst_n),
		.if_insn          (if_insn),
		.id_pc            (id_pc),
		.id_freeze        (id_freeze),
		.flushpipe        (flushpipe),
		.id_insn          (id_insn),
		.rf_addra         (rf_addra),
		.rf_addrb         (rf_addrb),
		.id_simm          (id_simm),
		.id_branch_target (id_branch_target),
		.id_branch_op     (id_branch_op),
		.sel_imm          (sel_imm)
	);

	ex_decode #(
		.link_reg (link_reg)
	) u_ex (
		.clk            (clk),
		.rst_n          (rst_n),
		.id_insn        (id_insn),
		.id_branch_op   (id_branch_op),
		.id_freeze      (id_freeze),
		.ex_freeze      (ex_freeze),
		.flushpipe      (flushpipe),
		.du_hwbkpt      (du_hwbkpt),
		.ex_insn        (ex_insn),
		.ex_branch_op   (ex_branch_op),
		.alu_op         (alu_op),
		.rfwb_op        (rfwb_op),
		.rf_addrw       (rf_addrw),
		.except_illegal (except_illegal),
		.sig_syscall    (sig_syscall),
		.sig_trap       (sig_trap)
	);

	forward_select u_fwd (
		.clk          (clk),
		.rst_n        (rst_n),
		.wb_freeze    (wb_freeze),
		.wbforw_valid (wbforw_valid),
		.id_insn      (id_insn),
		.ex_insn      (ex_insn),
		.rf_addrw     (rf_addrw),
		.rfwb_op      (rfwb_op),
		.sel_imm      (sel_imm),
		.wb_insn      (wb_insn),
		.sel_a        (sel_a),
		.sel_b        (sel_b)
	);

endmodule

`default_nettype wire

// File: forward_select.sv
////////////////////////////////////////
// WB copies ignore flushes; wbforw_valid qualifies WB forwarding
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module forward_select (
	input  wire                                   clk,
	input  wire                                   rst_n,
	input  wire                                   wb_freeze,
	input  wire                                   wbforw_valid,
	input  wire  [31:0]                           id_insn,
	input  wire  [31:0]                           ex_insn,
	input  wire  [or_ctrl_pkg::rf_addr_w-1:0]     rf_addrw,
	input  wire  or_ctrl_pkg::rfwb_op_t           rfwb_op,
	input  wire                                   sel_imm,
	output logic [31:0]                           wb_insn,
	output or_ctrl_pkg::sel_t                     sel_a,
	output or_ctrl_pkg::sel_t                     sel_b
);

	import or_ctrl_pkg::*;

	logic [rf_addr_w-1:0] wb_rfaddrw;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_insn    <= insn_nop;
			wb_rfaddrw <= '0;
		end else if (!wb_freeze) begin
			wb_insn    <= ex_insn;
			wb_rfaddrw <= rf_addrw;
		end
	end

	// youngest producer wins
	function automatic sel_t fwd_src(input logic [rf_addr_w-1:0] addr);
		if (addr == rf_addrw && rfwb_op[0])
			return sel_src_ex_forw;
		else if (addr == wb_rfaddrw && wbforw_valid)
			return sel_src_wb_forw;
		else
			return sel_src_rf;
	endfunction

	always_comb begin
		sel_a = fwd_src(id_insn[20:16]);
		if (sel_imm)
			sel_b = sel_src_imm;
		else
			sel_b = fwd_src(id_insn[15:11]);
	end

endmodule

`default_nettype wire

// File: ex_decode.sv
////////////////////////////////////////
// EX bubble needs ex_freeze low; ex_freeze holds everything,
// a pending flush included
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ex_decode #(
	parameter logic [or_ctrl_pkg::rf_addr_w-1:0] link_reg = 5'd9
) (
	input  wire                                   clk,
	input  wire                                   rst_n,
	input  wire  [31:0]                           id_insn,
	input  wire  or_ctrl_pkg::branch_op_t         id_branch_op,
	input  wire                                   id_freeze,
	input  wire                                   ex_freeze,
	input  wire                                   flushpipe,
	input  wire                                   du_hwbkpt,
	output logic [31:0]                           ex_insn,
	output or_ctrl_pkg::branch_op_t               ex_branch_op,
	output or_ctrl_pkg::alu_op_t                  alu_op,
	output or_ctrl_pkg::rfwb_op_t                 rfwb_op,
	output logic [or_ctrl_pkg::rf_addr_w-1:0]     rf_addrw,
	output logic                                  except_illegal,
	output logic                                  sig_syscall,
	output logic                                  sig_trap
);

	import or_ctrl_pkg::*;

	opcode_t              id_opc;
	alu_op_t              dec_alu_op;
	rfwb_op_t             dec_rfwb_op;
	logic [rf_addr_w-1:0] dec_addrw;
	logic                 dec_illegal;
	logic                 dec_syscall;
	logic                 dec_trap;
	logic                 bubble;

	assign id_opc = opcode_t'(id_insn[31:26]);

	// EX moves on while ID stalls, or the pipe is flushed
	assign bubble = !ex_freeze && (id_freeze || flushpipe);

	////////////////////////////////////////
	// operation decode
	////////////////////////////////////////
	always_comb begin
		dec_alu_op  = alu_nop;
		dec_rfwb_op = rfwb_nop;
		dec_illegal = 1'b0;
		case (id_opc)
			op_jal, op_jalr:
				dec_rfwb_op = rfwb_lr_w;
			op_lwz:
				dec_rfwb_op = rfwb_lsu_w;
			op_movhi: begin
				dec_alu_op  = alu_movhi;
				dec_rfwb_op = rfwb_alu_w;
			end
			op_addi: begin
				dec_alu_op  = alu_add;
				dec_rfwb_op = rfwb_alu_w;
			end
			op_andi: begin
				dec_alu_op  = alu_and;
				dec_rfwb_op = rfwb_alu_w;
			end
			op_ori: begin
				dec_alu_op  = alu_or;
				dec_rfwb_op = rfwb_alu_w;
			end
			op_xori: begin
				dec_alu_op  = alu_xor;
				dec_rfwb_op = rfwb_alu_w;
			end
			// set-flag compares, result goes to SR only
			op_sfxx, op_sfxxi:
				dec_alu_op = alu_comp;
			op_alu: begin
				dec_alu_op  = alu_op_t'({1'b0, id_insn[3:0]});
				dec_rfwb_op = rfwb_alu_w;
			end
			// legal, nothing for the ALU or write-back
			op_j, op_bnf, op_bf, op_nop, op_xsync, op_rfe, op_jr, op_sw:
				dec_illegal = 1'b0;
			default:
				dec_illegal = 1'b1;
		endcase
	end

	// jump-and-link writes the link register
	assign dec_addrw = (id_opc == op_jal || id_opc == op_jalr) ? link_reg : id_insn[25:21];

	// l.sys is xsync/000, l.trap is xsync/010
	assign dec_syscall = (id_insn[31:23] == {op_xsync, 3'b000});
	assign dec_trap    = (id_insn[31:23] == {op_xsync, 3'b010}) || du_hwbkpt;

	////////////////////////////////////////
	// EX registers
	////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_insn        <= insn_nop;
			ex_branch_op   <= br_nop;
			alu_op         <= alu_nop;
			rfwb_op        <= rfwb_nop;
			rf_addrw       <= '0;
			except_illegal <= 1'b0;
			sig_syscall    <= 1'b0;
			sig_trap       <= 1'b0;
		end else if (bubble) begin
			ex_insn        <= insn_nop;
			ex_branch_op   <= br_nop;
			alu_op         <= alu_nop;
			rfwb_op        <= rfwb_nop;
			rf_addrw       <= '0;
			except_illegal <= 1'b0;
			sig_syscall    <= 1'b0;
			sig_trap       <= 1'b0;
		end else if (!ex_freeze) begin
			ex_insn        <= id_insn;
			ex_branch_op   <= id_branch_op;
			alu_op         <= dec_alu_op;
			rfwb_op        <= dec_rfwb_op;
			rf_addrw       <= dec_addrw;
			except_illegal <= dec_illegal;
			sig_syscall    <= dec_syscall;
			sig_trap       <= dec_trap;
		end
	end

endmodule

`default_nettype wire

// File: id_stage.sv
////////////////////////////////////////
// flushpipe beats id_freeze; sel_imm follows if_insn
// and is not cleared by a flush
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module id_stage (
	input  wire                                   clk,
	input  wire                                   rst_n,
	input  wire  [31:0]                           if_insn,
	input  wire  [31:0]                           id_pc,
	input  wire                                   id_freeze,
	input  wire                                   flushpipe,
	output logic [31:0]                           id_insn,
	output logic [or_ctrl_pkg::rf_addr_w-1:0]     rf_addra,
	output logic [or_ctrl_pkg::rf_addr_w-1:0]     rf_addrb,
	output logic [31:0]                           id_simm,
	output logic [29:0]                           id_branch_target,
	output or_ctrl_pkg::branch_op_t               id_branch_op,
	output logic                                  sel_imm
);

	import or_ctrl_pkg::*;

	opcode_t    if_opc;
	opcode_t    id_opc;
	branch_op_t nxt_branch_op;
	logic       nxt_sel_imm;

	assign if_opc = opcode_t'(if_insn[31:26]);
	assign id_opc = opcode_t'(id_insn[31:26]);

	// read ports are addressed straight from fetch
	assign rf_addra = if_insn[20:16];
	assign rf_addrb = if_insn[15:11];

	////////////////////////////////////////
	// decode of the incoming word
	////////////////////////////////////////
	always_comb begin
		case (if_opc)
			op_j, op_jal:   nxt_branch_op = br_j;
			op_jr, op_jalr: nxt_branch_op = br_jr;
			op_bnf:         nxt_branch_op = br_bnf;
			op_bf:          nxt_branch_op = br_bf;
			op_rfe:         nxt_branch_op = br_rfe;
			default:        nxt_branch_op = br_nop;
		endcase
	end

	// register-only operand b
	always_comb begin
		case (if_opc)
			op_jalr, op_jr, op_rfe, op_xsync, op_sw, op_alu, op_sfxx, op_nop:
				nxt_sel_imm = 1'b0;
			default:
				nxt_sel_imm = 1'b1;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_insn      <= insn_nop;
			id_branch_op <= br_nop;
			sel_imm      <= 1'b0;
		end else if (flushpipe) begin
			id_insn      <= insn_nop;
			id_branch_op <= br_nop;
			if (!id_freeze)
				sel_imm <= nxt_sel_imm;
		end else if (!id_freeze) begin
			id_insn      <= if_insn;
			id_branch_op <= nxt_branch_op;
			sel_imm      <= nxt_sel_imm;
		end
	end

	////////////////////////////////////////
	// immediate extension
	////////////////////////////////////////
	always_comb begin
		case (id_opc)
			op_addi, op_lwz, op_xori, op_sfxxi:
				id_simm = {{16{id_insn[15]}}, id_insn[15:0]};
			// store offset is split around rB
			op_sw:
				id_simm = {{16{id_insn[25]}}, id_insn[25:21], id_insn[10:0]};
			default:
				id_simm = {16'h0000, id_insn[15:0]};
		endcase
	end

	// word-aligned target, 26-bit signed offset
	assign id_branch_target = {{4{id_insn[25]}}, id_insn[25:0]} + id_pc[31:2];

endmodule

`default_nettype wire

// File: or_ctrl_pkg.sv
////////////////////////////////////////
// encodings follow the OR1K major opcode map
// opcodes missing from opcode_t decode as illegal
////////////////////////////////////////
`default_nettype none

package or_ctrl_pkg;

	// register file address width
	localparam int rf_addr_w = 5;

	////////////////////////////////////////
	// major opcode, insn[31:26]
	////////////////////////////////////////
	typedef enum logic [5:0] {
		op_j     = 6'h00,
		op_jal   = 6'h01,
		op_bnf   = 6'h03,
		op_bf    = 6'h04,
		op_nop   = 6'h05,
		op_movhi = 6'h06,
		// l.sys, l.trap and the sync group
		op_xsync = 6'h08,
		op_rfe   = 6'h09,
		op_jr    = 6'h11,
		op_jalr  = 6'h12,
		op_lwz   = 6'h21,
		op_addi  = 6'h27,
		op_andi  = 6'h29,
		op_ori   = 6'h2a,
		op_xori  = 6'h2b,
		op_sfxxi = 6'h2f,
		op_sw    = 6'h35,
		// register-register ALU group
		op_alu   = 6'h38,
		op_sfxx  = 6'h39
	} opcode_t;

	////////////////////////////////////////
	// branch kind
	////////////////////////////////////////
	typedef enum logic [2:0] {
		br_nop = 3'd0,
		br_j   = 3'd1,
		br_jr  = 3'd2,
		br_bnf = 3'd5,
		br_bf  = 3'd4,
		br_rfe = 3'd6
	} branch_op_t;

	////////////////////////////////////////
	// ALU operation
	////////////////////////////////////////
	// the ALU opcode group passes its low four function bits,
	// so any 4-bit code below 0x10 is a valid operation
	typedef enum logic [4:0] {
		alu_add   = 5'h00,
		alu_addc  = 5'h01,
		alu_and   = 5'h03,
		alu_or    = 5'h04,
		alu_xor   = 5'h05,
		alu_movhi = 5'h0c,
		alu_comp  = 5'h0e,
		alu_nop   = 5'h0f
	} alu_op_t;

	////////////////////////////////////////
	// register file write-back
	////////////////////////////////////////
	// bits 3:1 source, bit 0 write enable
	// sources: 000 alu, 001 load, 011 link
	typedef enum logic [3:0] {
		rfwb_nop   = 4'b0000,
		rfwb_alu_w = 4'b0001,
		rfwb_lsu_w = 4'b0011,
		rfwb_lr_w  = 4'b0111
	} rfwb_op_t;

	// operand source for the ALU inputs
	typedef enum logic [1:0] {
		sel_src_rf      = 2'd0,
		sel_src_imm     = 2'd1,
		sel_src_ex_forw = 2'd2,
		sel_src_wb_forw = 2'd3
	} sel_t;

	// void nop, bit 16 marks it as pipeline filler
	localparam logic [31:0] insn_nop = {op_nop, 10'b00_0000_0001, 16'h0000};

endpackage

`default_nettype wire
